//--- src.f
design/lsu_pkg.sv
design/store_align.sv
design/load_extract.sv
design/bus_sequencer.sv
design/lsu_top.sv
test/lsu_props.sv
test/lsu_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f src.f \
   && ./obj_dir/Vlsu_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

   localparam int NUM_REQ = 300;
   // Gap, wait states and rsp_ready stalls stay well under 13 cycles per request
   localparam int MAX_CYCLES = NUM_REQ * 13 + 100;

   logic           clk;
   logic           rst_n;
   logic           req_valid, req_ready, req_write, req_signed;
   lsu_pkg::size_t req_size, hsize;
   lsu_pkg::word_t req_addr, req_wdata, haddr, hwdata, hrdata, rsp_data;
   lsu_pkg::tag_t  req_tag, rsp_tag;
   logic           rsp_valid, rsp_ready, rsp_load;
   logic           htrans, hwrite, hready;
   lsu_pkg::strb_t hwstrb;

   logic [31:0]    lfsr;
   lsu_pkg::word_t slave_mem [64];
   lsu_pkg::word_t shadow_mem [64];
   // Expected responses as {tag, load, data}
   logic [37:0]    exp_q [$];
   logic [37:0]    exp_rsp;
   logic           dp_valid, dp_write, done;
   lsu_pkg::word_t dp_addr;
   lsu_pkg::size_t dp_size;
   int             issued, taken, mismatches, failures, cycles;

   lsu_top lsu_top_i (.*);

   // ==================================================
   // Reference rules
   // ==================================================

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic lsu_pkg::word_t fill_word(int idx);
      return lsu_pkg::word_t'(idx + 1) * 32'h9e37_79b9;
   endfunction

   function automatic lsu_pkg::strb_t lane_mask(lsu_pkg::size_t size, lsu_pkg::word_t addr);
      case (size)
         lsu_pkg::SIZE_BYTE: return 4'b0001 << addr[1:0];
         lsu_pkg::SIZE_HALF: return addr[1] ? 4'b1100 : 4'b0011;
         default:            return 4'b1111;
      endcase
   endfunction

   // Low bytes of the write data fill the enabled lanes from the bottom up
   task automatic shadow_store(lsu_pkg::size_t size, lsu_pkg::word_t addr, lsu_pkg::word_t wd);
      lsu_pkg::strb_t m;
      int             k;
      m = lane_mask(size, addr);
      k = 0;
      for (int b = 0; b < 4; b++) begin
         if (m[b]) begin
            shadow_mem[addr[7:2]][8*b +: 8] = wd[8*k +: 8];
            k++;
         end
      end
   endtask

   function automatic lsu_pkg::word_t load_value(lsu_pkg::size_t size, logic sgn,
                                                 lsu_pkg::word_t addr);
      lsu_pkg::word_t r;
      r = shadow_mem[addr[7:2]] >> (8 * int'(addr[1:0]));
      case (size)
         lsu_pkg::SIZE_BYTE: r = {{24{sgn & r[7]}}, r[7:0]};
         lsu_pkg::SIZE_HALF: r = {{16{sgn & r[15]}}, r[15:0]};
         default:            r = shadow_mem[addr[7:2]];
      endcase
      return r;
   endfunction

   task automatic compare(string name, lsu_pkg::word_t got, lsu_pkg::word_t want);
      assert (got == want) else begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
         mismatches++;
      end
   endtask

   task automatic drive_request();
      lsu_pkg::size_t size;
      lsu_pkg::lane_t off;
      size = lsu_pkg::size_t'(rand_bits(2));
      if (size == 2'd3) size = lsu_pkg::SIZE_WORD;
      off = lsu_pkg::lane_t'(rand_bits(2));
      if (size == lsu_pkg::SIZE_HALF) off[0] = 1'b0;
      if (size == lsu_pkg::SIZE_WORD) off = '0;
      req_valid  <= 1'b1;
      req_write  <= 1'(rand_bits(1));
      req_size   <= size;
      req_signed <= 1'(rand_bits(1));
      // 16 words so that loads often hit earlier stores
      req_addr   <= {24'h20_0000, 2'b00, 4'(rand_bits(4)), off};
      req_wdata  <= rand_bits(32);
      req_tag    <= lsu_pkg::tag_t'(rand_bits(5));
      issued++;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ==================================================
   // Bus slave, request driver and response checker
   // ==================================================

   always @(posedge clk) begin
      if (rst_n) begin
         if (dp_valid && hready && dp_write) begin
            compare("hwstrb", lsu_pkg::word_t'(hwstrb),
                    lsu_pkg::word_t'(lane_mask(dp_size, dp_addr)));
            for (int b = 0; b < 4; b++) begin
               if (hwstrb[b]) slave_mem[dp_addr[7:2]][8*b +: 8] = hwdata[8*b +: 8];
            end
         end
         // Address phase mirrors the accepted request
         compare("htrans", lsu_pkg::word_t'(htrans), lsu_pkg::word_t'(req_valid && req_ready));
         if (htrans) begin
            compare("haddr", haddr, req_addr);
            compare("hsize", lsu_pkg::word_t'(hsize), lsu_pkg::word_t'(req_size));
            compare("hwrite", lsu_pkg::word_t'(hwrite), lsu_pkg::word_t'(req_write));
            dp_valid <= 1'b1;
            dp_addr  <= haddr;
            dp_write <= hwrite;
            dp_size  <= hsize;
            hrdata   <= slave_mem[haddr[7:2]];
         end else if (hready) begin
            dp_valid <= 1'b0;
         end
         hready <= (rand_bits(8) % 3) != 0;

         // Expected results are fixed at acceptance in request order
         if (req_valid && req_ready) begin
            if (req_write) begin
               shadow_store(req_size, req_addr, req_wdata);
               exp_q.push_back({req_tag, 1'b0, 32'h0});
            end else begin
               exp_q.push_back({req_tag, 1'b1, load_value(req_size, req_signed, req_addr)});
            end
         end
         if (!req_valid || req_ready) begin
            if (issued < NUM_REQ && rand_bits(2) != 0) drive_request();
            else req_valid <= 1'b0;
         end

         if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
               $display("Response with tag %0d at %0t has no outstanding request", rsp_tag, $time);
               failures++;
            end else begin
               exp_rsp = exp_q.pop_front();
               compare("rsp_tag", lsu_pkg::word_t'(rsp_tag), lsu_pkg::word_t'(exp_rsp[37:33]));
               compare("rsp_load", lsu_pkg::word_t'(rsp_load), lsu_pkg::word_t'(exp_rsp[32]));
               compare("rsp_data", rsp_data, exp_rsp[31:0]);
            end
            taken++;
         end
         rsp_ready <= rand_bits(2) != 0;
         done <= (taken >= NUM_REQ);
      end
   end

   initial begin
      lfsr = 32'h2480_8bec;
      rst_n = 1'b0;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_size = lsu_pkg::SIZE_WORD;
      req_signed = 1'b0;
      req_addr = '0;
      req_wdata = '0;
      req_tag = '0;
      rsp_ready = 1'b0;
      hrdata = '0;
      hready = 1'b1;
      dp_valid = 1'b0;
      dp_write = 1'b0;
      dp_addr = '0;
      dp_size = lsu_pkg::SIZE_WORD;
      done = 1'b0;
      issued = 0;
      taken = 0;
      mismatches = 0;
      failures = 0;
      cycles = 0;
      for (int i = 0; i < 64; i++) begin
         slave_mem[i] = fill_word(i);
         shadow_mem[i] = fill_word(i);
      end
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      while (!done && cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         $display("Timeout after %0d cycles with %0d of %0d responses taken", cycles, taken,
                  NUM_REQ);
         failures++;
      end
      $display("Closing: %0d responses, %0d mismatches, %0d other errors", taken, mismatches,
               failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/lsu_props.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_props (
   input logic           clk,
   input logic           rst_n,
   input logic           rsp_valid,
   input logic           rsp_ready,
   input lsu_pkg::tag_t  rsp_tag,
   input logic           rsp_load,
   input lsu_pkg::word_t rsp_data,
   input logic           htrans
);

   // Bus transfers whose response has not been taken yet
   int outstanding;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(htrans) - int'(rsp_valid && rsp_ready);
      end
   end

   // ==================================================
   // Response port
   // ==================================================

   // Stalled response keeps its fields
   hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_tag) && $stable(rsp_load)
                                  && $stable(rsp_data))
      else $error("response fields changed while rsp_ready was low");

   // New transfer only when the queue can take its response
   room_a: assert property (@(posedge clk) disable iff (!rst_n)
      htrans |-> outstanding - int'(rsp_valid && rsp_ready) < lsu_pkg::RSP_DEPTH)
      else $error("address phase issued with no room in the response queue");

   // Quiet bus and response port right after reset
   reset_a: assert property (@(posedge clk) $rose(rst_n) |-> !rsp_valid && !htrans)
      else $error("rsp_valid or htrans high in the first cycle after reset");

endmodule

bind lsu_top lsu_props lsu_props_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .rsp_tag   (rsp_tag),
   .rsp_load  (rsp_load),
   .rsp_data  (rsp_data),
   .htrans    (htrans)
);

`default_nettype wire

//--- design/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
   input  logic           clk,
   input  logic           rst_n,

   // Core request
   input  logic           req_valid,
   output logic           req_ready,
   input  logic           req_write,
   input  lsu_pkg::size_t req_size,
   input  logic           req_signed,
   input  lsu_pkg::word_t req_addr,
   input  lsu_pkg::word_t req_wdata,
   input  lsu_pkg::tag_t  req_tag,

   // Tagged response
   output logic           rsp_valid,
   input  logic           rsp_ready,
   output lsu_pkg::tag_t  rsp_tag,
   output logic           rsp_load,
   output lsu_pkg::word_t rsp_data,

   // AHB-lite style data bus
   output lsu_pkg::word_t haddr,
   output logic           htrans,
   output logic           hwrite,
   output lsu_pkg::size_t hsize,
   output lsu_pkg::word_t hwdata,
   output lsu_pkg::strb_t hwstrb,
   input  lsu_pkg::word_t hrdata,
   input  logic           hready
);

   logic           accept;
   lsu_pkg::word_t load_data;

   // Address phase comes straight from the request
   assign haddr  = req_addr;
   assign hwrite = req_write;
   assign hsize  = req_size;
   assign htrans = accept;

   store_align store_align_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .accept    (accept),
      .req_size  (req_size),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .hwdata    (hwdata),
      .hwstrb    (hwstrb)
   );

   load_extract load_extract_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .accept     (accept),
      .req_size   (req_size),
      .req_signed (req_signed),
      .req_addr   (req_addr),
      .hrdata     (hrdata),
      .load_data  (load_data)
   );

   bus_sequencer bus_sequencer_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_write (req_write),
      .req_tag   (req_tag),
      .req_ready (req_ready),
      .accept    (accept),
      .hready    (hready),
      .load_data (load_data),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_tag   (rsp_tag),
      .rsp_load  (rsp_load),
      .rsp_data  (rsp_data)
   );

endmodule

`default_nettype wire

//--- design/bus_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module bus_sequencer (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           req_valid,
   input  logic           req_write,
   input  lsu_pkg::tag_t  req_tag,
   output logic           req_ready,
   output logic           accept,
   input  logic           hready,
   input  lsu_pkg::word_t load_data,
   output logic           rsp_valid,
   input  logic           rsp_ready,
   output lsu_pkg::tag_t  rsp_tag,
   output logic           rsp_load,
   output lsu_pkg::word_t rsp_data
);

   // Transfer currently in its data phase
   logic              pend;
   lsu_pkg::tag_t     pend_tag;
   logic              pend_load;

   // Response queue storage
   lsu_pkg::tag_t     q_tag  [lsu_pkg::RSP_DEPTH];
   logic              q_load [lsu_pkg::RSP_DEPTH];
   lsu_pkg::word_t    q_data [lsu_pkg::RSP_DEPTH];
   lsu_pkg::rsp_ptr_t wr_ptr;
   lsu_pkg::rsp_ptr_t rd_ptr;
   lsu_pkg::rsp_cnt_t cnt;

   lsu_pkg::rsp_cnt_t occ;
   logic              room;
   logic              push;
   logic              pop;

   // ==================================================
   // Request acceptance
   // ==================================================

   assign pop  = rsp_valid & rsp_ready;
   assign push = pend & hready;

   // Queue entries plus the data phase in flight less what drains now
   assign occ  = cnt + lsu_pkg::rsp_cnt_t'(pend) - lsu_pkg::rsp_cnt_t'(pop);
   assign room = occ < lsu_pkg::RSP_FULL;

   assign req_ready = hready & room;
   assign accept    = req_valid & req_ready;

   // ==================================================
   // Data phase tracking
   // ==================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend <= 1'b0;
      end else if (hready) begin
         // Data phase ends and the next one starts only on hready
         pend <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         pend_tag  <= req_tag;
         pend_load <= ~req_write;
      end
   end

   // ==================================================
   // Response queue
   // ==================================================

   always_ff @(posedge clk) begin
      if (push) begin
         q_tag[wr_ptr]  <= pend_tag;
         q_load[wr_ptr] <= pend_load;
         // Stores report zero data
         q_data[wr_ptr] <= pend_load ? load_data : '0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (push) begin
            if (wr_ptr == lsu_pkg::RSP_LAST) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (pop) begin
            if (rd_ptr == lsu_pkg::RSP_LAST) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         case ({push, pop})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;
         endcase
      end
   end

   // Head of the queue drives the response port
   assign rsp_valid = (cnt != '0);
   assign rsp_tag   = q_tag[rd_ptr];
   assign rsp_load  = q_load[rd_ptr];
   assign rsp_data  = q_data[rd_ptr];

endmodule

`default_nettype wire

//--- design/load_extract.sv
`timescale 1ns/10ps
`default_nettype none

module load_extract (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           accept,
   input  lsu_pkg::size_t req_size,
   input  logic           req_signed,
   input  lsu_pkg::word_t req_addr,
   input  lsu_pkg::word_t hrdata,
   output lsu_pkg::word_t load_data
);

   lsu_pkg::size_t size_q;
   logic           signed_q;
   lsu_pkg::lane_t lane_q;
   logic [7:0]     byte_sel;
   logic [15:0]    half_sel;

   // ==================================================
   // Load attributes for the data phase
   // ==================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         size_q   <= lsu_pkg::SIZE_WORD;
         signed_q <= 1'b0;
         lane_q   <= '0;
      end else if (accept) begin
         size_q   <= req_size;
         signed_q <= req_signed;
         lane_q   <= req_addr[1:0];
      end
   end

   // ==================================================
   // Lane selection and extension
   // ==================================================

   always_comb begin
      case (lane_q)
         2'd0:    byte_sel = hrdata[7:0];
         2'd1:    byte_sel = hrdata[15:8];
         2'd2:    byte_sel = hrdata[23:16];
         default: byte_sel = hrdata[31:24];
      endcase
   end

   // Halfword lane only looks at bit 1
   assign half_sel = lane_q[1] ? hrdata[31:16] : hrdata[15:0];

   always_comb begin
      case (size_q)
         lsu_pkg::SIZE_BYTE: begin
            load_data = {{(lsu_pkg::WORD_W - 8){signed_q & byte_sel[7]}}, byte_sel};
         end
         lsu_pkg::SIZE_HALF: begin
            load_data = {{(lsu_pkg::WORD_W - 16){signed_q & half_sel[15]}}, half_sel};
         end
         default: begin
            // Full word passes through
            load_data = hrdata;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/store_align.sv
`timescale 1ns/10ps
`default_nettype none

module store_align (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           accept,
   input  lsu_pkg::size_t req_size,
   input  lsu_pkg::word_t req_addr,
   input  lsu_pkg::word_t req_wdata,
   output lsu_pkg::word_t hwdata,
   output lsu_pkg::strb_t hwstrb
);

   lsu_pkg::lane_t lane;
   lsu_pkg::word_t place_data;
   lsu_pkg::strb_t place_strb;

   // Only the low address bits pick the lane
   assign lane = req_addr[1:0];

   // ==================================================
   // Lane placement during the address phase
   // ==================================================

   always_comb begin
      case (req_size)
         lsu_pkg::SIZE_BYTE: begin
            // Low byte moved to lane 0..3
            place_data = lsu_pkg::word_t'(req_wdata[7:0]) << {lane, 3'b000};
            place_strb = lsu_pkg::strb_t'(1'b1) << lane;
         end
         lsu_pkg::SIZE_HALF: begin
            // Address bit 1 picks the upper or lower half
            place_data = lsu_pkg::word_t'(req_wdata[15:0]) << {lane[1], 4'b0000};
            place_strb = lsu_pkg::strb_t'(2'b11) << {lane[1], 1'b0};
         end
         default: begin
            place_data = req_wdata;
            place_strb = '1;
         end
      endcase
   end

   // ==================================================
   // Data phase registers
   // ==================================================

   // Strobes for the data phase
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwstrb <= '0;
      end else if (accept) begin
         hwstrb <= place_strb;
      end
   end

   // Write data held until the next accepted transfer
   always_ff @(posedge clk) begin
      if (accept) begin
         hwdata <= place_data;
      end
   end

endmodule

`default_nettype wire

//--- design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   // ==================================================
   // Widths
   // ==================================================

   localparam int WORD_W = 32;
   localparam int STRB_W = WORD_W / 8;
   localparam int TAG_W  = 5;
   localparam int SIZE_W = 2;
   localparam int LANE_W = 2;

   // Data and address word
   typedef logic [WORD_W-1:0] word_t;

   // One strobe per byte lane
   typedef logic [STRB_W-1:0] strb_t;

   // Destination register index
   typedef logic [TAG_W-1:0] tag_t;

   // Transfer size in bus hsize encoding
   typedef logic [SIZE_W-1:0] size_t;

   // Byte offset inside a word
   typedef logic [LANE_W-1:0] lane_t;

   // ==================================================
   // Size encodings
   // ==================================================

   localparam size_t SIZE_BYTE = 2'd0;
   localparam size_t SIZE_HALF = 2'd1;
   localparam size_t SIZE_WORD = 2'd2;

   // ==================================================
   // Response queue
   // ==================================================

   localparam int RSP_DEPTH = 2;

   // Pointer and fill count widths
   localparam int RSP_PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
   localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);

   typedef logic [RSP_PTR_W-1:0] rsp_ptr_t;
   typedef logic [RSP_CNT_W-1:0] rsp_cnt_t;

   // Last valid slot index before the pointers wrap
   localparam rsp_ptr_t RSP_LAST = rsp_ptr_t'(RSP_DEPTH - 1);

   // Fill level at which no new transfer may start
   localparam rsp_cnt_t RSP_FULL = rsp_cnt_t'(RSP_DEPTH);

endpackage

`default_nettype wire
